//--- hdl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath and register index widths
`define CPU_WORD_W      16
`define CPU_REG_ADDR_W  4
`define CPU_PC_STEP     2
`define CPU_BR_OFF_W    9   // signed word offset of B
`define CPU_MEM_OFF_W   4   // signed word offset of LW and SW

// opcodes sit in the top nibble of every instruction word
`define CPU_OP_ADD      4'd0
`define CPU_OP_SUB      4'd1
`define CPU_OP_XOR      4'd2
`define CPU_OP_RED      4'd3
`define CPU_OP_SLL      4'd4
`define CPU_OP_SRA      4'd5
`define CPU_OP_ROR      4'd6
`define CPU_OP_PADDSB   4'd7
`define CPU_OP_LW       4'd8
`define CPU_OP_SW       4'd9
`define CPU_OP_LLB      4'd10
`define CPU_OP_LHB      4'd11
`define CPU_OP_B        4'd12
`define CPU_OP_BR       4'd13
`define CPU_OP_PCS      4'd14
`define CPU_OP_HLT      4'd15

// branch condition codes
`define CPU_CC_NE       3'd0
`define CPU_CC_EQ       3'd1
`define CPU_CC_GT       3'd2
`define CPU_CC_LT       3'd3
`define CPU_CC_GE       3'd4
`define CPU_CC_LE       3'd5
`define CPU_CC_OV       3'd6
`define CPU_CC_UN       3'd7

`endif

//--- hdl/cpuPkg.sv
`default_nettype none
`include "cpu_cfg.svh"

package cpuPkg;

  // rt doubles as the shift amount and the memory offset
  typedef struct packed {
    logic [3:0]                 opcode;
    logic [`CPU_REG_ADDR_W-1:0] rd;
    logic [`CPU_REG_ADDR_W-1:0] rs;
    logic [`CPU_REG_ADDR_W-1:0] rt;
  } regFmt_t;

  typedef struct packed {
    logic [3:0]                 opcode;
    logic [`CPU_REG_ADDR_W-1:0] rd;
    logic [7:0]                 imm8;
  } byteFmt_t;

  typedef struct packed {
    logic [3:0]               opcode;
    logic [2:0]               cond;
    logic [`CPU_BR_OFF_W-1:0] offset;
  } brFmt_t;

  typedef union packed {
    regFmt_t  r;
    byteFmt_t imm;
    brFmt_t   br;
  } instWord_t;

  // instructions that end with a register file write
  function automatic logic writesReg(input logic [3:0] op);
    case (op)
      `CPU_OP_ADD, `CPU_OP_SUB, `CPU_OP_XOR, `CPU_OP_SLL, `CPU_OP_SRA, `CPU_OP_ROR,
      `CPU_OP_LW, `CPU_OP_LLB, `CPU_OP_LHB, `CPU_OP_PCS:
        writesReg = 1'b1;
      default:
        writesReg = 1'b0;
    endcase
  endfunction

  // instructions that update at least the zero flag
  function automatic logic setsFlags(input logic [3:0] op);
    case (op)
      `CPU_OP_ADD, `CPU_OP_SUB, `CPU_OP_XOR, `CPU_OP_SLL, `CPU_OP_SRA, `CPU_OP_ROR:
        setsFlags = 1'b1;
      default:
        setsFlags = 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- hdl/registerFile.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module registerFile (
  input  logic                       clk,
  input  logic                       arstN,
  input  logic [`CPU_REG_ADDR_W-1:0] rsAddr,
  input  logic [`CPU_REG_ADDR_W-1:0] rtAddr,
  output logic [`CPU_WORD_W-1:0]     rsData,
  output logic [`CPU_WORD_W-1:0]     rtData,
  input  logic                       wrEn,
  input  logic [`CPU_REG_ADDR_W-1:0] wrAddr,
  input  logic [`CPU_WORD_W-1:0]     wrData
);

  localparam int Depth = 1 << `CPU_REG_ADDR_W;

  logic [`CPU_WORD_W-1:0] regs [Depth];

  // writeback lands in the same cycle that decode reads, so the write bypasses
  assign rsData = (rsAddr == '0) ? '0 :
                  (wrEn && wrAddr == rsAddr) ? wrData : regs[rsAddr];
  assign rtData = (rtAddr == '0) ? '0 :
                  (wrEn && wrAddr == rtAddr) ? wrData : regs[rtAddr];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < Depth; i++)
        regs[i] <= '0;
    end else if (wrEn && wrAddr != '0) begin
      regs[wrAddr] <= wrData;  // register 0 is never written
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetchStage.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module fetchStage (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic [`CPU_WORD_W-1:0] instData,
  input  logic                   stall,
  input  logic                   brTaken,
  input  logic [`CPU_WORD_W-1:0] brTarget,
  output logic [`CPU_WORD_W-1:0] pc,
  output cpuPkg::instWord_t      ifIdInst,
  output logic [`CPU_WORD_W-1:0] ifIdPcInc,
  output logic                   ifIdValid
);
  import cpuPkg::*;

  instWord_t              fetched;
  logic [`CPU_WORD_W-1:0] pcInc;
  logic [`CPU_WORD_W-1:0] pcNext;
  logic                   isHalt;

  assign fetched = instData;
  assign pcInc   = pc + `CPU_PC_STEP;
  assign isHalt  = fetched.r.opcode == `CPU_OP_HLT;

  // a taken branch wins over the hold, so an HLT fetched on the wrong path is dropped
  always_comb begin
    if (brTaken)
      pcNext = brTarget;
    else if (stall || isHalt)
      pcNext = pc;  // pc parks on the HLT address
    else
      pcNext = pcInc;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc        <= '0;
      ifIdValid <= 1'b0;
    end else begin
      pc <= pcNext;
      if (!stall)
        ifIdValid <= !brTaken;  // the slot behind a taken branch becomes a bubble
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ifIdInst  <= fetched;
      ifIdPcInc <= pcInc;
    end
  end

endmodule

`default_nettype wire

//--- hdl/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module decodeStage (
  input  logic                       clk,
  input  logic                       arstN,
  input  cpuPkg::instWord_t          ifIdInst,
  input  logic [`CPU_WORD_W-1:0]     ifIdPcInc,
  input  logic                       ifIdValid,
  input  logic                       zFlag,
  input  logic                       vFlag,
  input  logic                       nFlag,
  input  cpuPkg::instWord_t          exMemInst,
  input  logic                       exMemValid,
  input  logic                       wbWrite,
  input  logic [`CPU_REG_ADDR_W-1:0] wbReg,
  input  logic [`CPU_WORD_W-1:0]     wbData,
  output logic                       stall,
  output logic                       brTaken,
  output logic [`CPU_WORD_W-1:0]     brTarget,
  output cpuPkg::instWord_t          idExInst,
  output logic [`CPU_WORD_W-1:0]     idExRsData,
  output logic [`CPU_WORD_W-1:0]     idExRtData,
  output logic [`CPU_WORD_W-1:0]     idExPcInc,
  output logic                       idExValid
);
  import cpuPkg::*;

  logic [3:0]                 op;
  logic [3:0]                 exOp;
  logic [`CPU_REG_ADDR_W-1:0] exRd;
  logic [`CPU_REG_ADDR_W-1:0] rtSel;
  logic [`CPU_WORD_W-1:0]     rsData;
  logic [`CPU_WORD_W-1:0]     rtData;
  logic [`CPU_WORD_W-1:0]     brOffset;
  logic                       readsRs;
  logic                       readsRt;
  logic                       useRd;
  logic                       isB;
  logic                       isBr;
  logic                       condMet;
  logic                       loadUse;
  logic                       flagHazard;
  logic                       brRegHazard;

  assign op   = ifIdInst.r.opcode;
  assign exOp = idExInst.r.opcode;
  assign exRd = idExInst.r.rd;
  assign isB  = op == `CPU_OP_B;
  assign isBr = op == `CPU_OP_BR;

  always_comb begin
    readsRs = 1'b0;
    readsRt = 1'b0;
    useRd   = 1'b0;
    case (op)
      `CPU_OP_ADD, `CPU_OP_SUB, `CPU_OP_XOR: begin
        readsRs = 1'b1;
        readsRt = 1'b1;
      end
      `CPU_OP_SLL, `CPU_OP_SRA, `CPU_OP_ROR, `CPU_OP_LW, `CPU_OP_BR:
        readsRs = 1'b1;
      `CPU_OP_SW: begin
        readsRs = 1'b1;
        useRd   = 1'b1;
      end
      `CPU_OP_LLB, `CPU_OP_LHB:
        useRd = 1'b1;  // the other byte of rd is kept
      default: ;
    endcase
  end

  // store data, LLB and LHB take rd through the second port
  assign rtSel = useRd ? ifIdInst.r.rd : ifIdInst.r.rt;

  registerFile regFile (
    .clk    (clk),
    .arstN  (arstN),
    .rsAddr (ifIdInst.r.rs),
    .rtAddr (rtSel),
    .rsData (rsData),
    .rtData (rtData),
    .wrEn   (wbWrite),
    .wrAddr (wbReg),
    .wrData (wbData)
  );

  always_comb begin
    case (ifIdInst.br.cond)
      `CPU_CC_NE: condMet = !zFlag;
      `CPU_CC_EQ: condMet = zFlag;
      `CPU_CC_GT: condMet = !zFlag && !nFlag;
      `CPU_CC_LT: condMet = nFlag;
      `CPU_CC_GE: condMet = zFlag || !nFlag;
      `CPU_CC_LE: condMet = zFlag || nFlag;
      `CPU_CC_OV: condMet = vFlag;
      default:    condMet = 1'b1;
    endcase
  end

  assign brOffset = {{(`CPU_WORD_W - `CPU_BR_OFF_W - 1){ifIdInst.br.offset[`CPU_BR_OFF_W-1]}},
                     ifIdInst.br.offset, 1'b0};
  assign brTarget = isBr ? rsData : ifIdPcInc + brOffset;

  // SW data is not part of load-use, store forwarding covers it in the memory stage
  assign loadUse = idExValid && exOp == `CPU_OP_LW &&
                   ((readsRs && ifIdInst.r.rs == exRd) ||
                    (readsRt && ifIdInst.r.rt == exRd) ||
                    (useRd && op != `CPU_OP_SW && ifIdInst.r.rd == exRd));
  assign flagHazard = (isB || isBr) && idExValid && setsFlags(exOp);
  // BR jumps to rs, whose producer must have reached writeback
  assign brRegHazard = isBr &&
                       ((idExValid && writesReg(exOp) && exRd == ifIdInst.r.rs) ||
                        (exMemValid && writesReg(exMemInst.r.opcode) &&
                         exMemInst.r.rd == ifIdInst.r.rs));

  assign stall   = ifIdValid && (loadUse || flagHazard || brRegHazard);
  assign brTaken = ifIdValid && (isB || isBr) && condMet && !stall;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)
      idExValid <= 1'b0;
    else
      idExValid <= ifIdValid && !stall;  // bubble into execute while held
  end

  always_ff @(posedge clk) begin
    idExInst   <= ifIdInst;
    idExRsData <= rsData;
    idExRtData <= rtData;
    idExPcInc  <= ifIdPcInc;
  end

endmodule

`default_nettype wire

//--- hdl/executeStage.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module executeStage (
  input  logic                       clk,
  input  logic                       arstN,
  input  cpuPkg::instWord_t          idExInst,
  input  logic [`CPU_WORD_W-1:0]     idExRsData,
  input  logic [`CPU_WORD_W-1:0]     idExRtData,
  input  logic [`CPU_WORD_W-1:0]     idExPcInc,
  input  logic                       idExValid,
  input  logic                       wbWrite,
  input  logic [`CPU_REG_ADDR_W-1:0] wbReg,
  input  logic [`CPU_WORD_W-1:0]     wbData,
  output logic                       zFlag,
  output logic                       vFlag,
  output logic                       nFlag,
  output cpuPkg::instWord_t          exMemInst,
  output logic                       exMemValid,
  output logic [`CPU_WORD_W-1:0]     exMemResult,
  output logic [`CPU_WORD_W-1:0]     exMemStoreData
);
  import cpuPkg::*;

  localparam int W = `CPU_WORD_W;

  logic [3:0]                 op;
  logic [`CPU_REG_ADDR_W-1:0] srcB;
  logic [`CPU_MEM_OFF_W-1:0]  offset;
  logic                       exFwd;
  logic                       wbFwd;
  logic [W-1:0]               a;
  logic [W-1:0]               b;
  logic [W-1:0]               sum;
  logic [W-1:0]               diff;
  logic [W-1:0]               satVal;
  logic [W-1:0]               memOff;
  logic [2*W-1:0]             rotPair;
  logic                       addOvf;
  logic                       subOvf;
  logic                       ovf;
  logic [W-1:0]               result;

  assign op     = idExInst.r.opcode;
  assign offset = idExInst.r.rt[`CPU_MEM_OFF_W-1:0];
  assign srcB   = (op == `CPU_OP_SW || op == `CPU_OP_LLB || op == `CPU_OP_LHB) ?
                  idExInst.r.rd : idExInst.r.rt;

  // a load in the memory stage only holds its address, so it is never a source here
  assign exFwd = exMemValid && writesReg(exMemInst.r.opcode) &&
                 exMemInst.r.opcode != `CPU_OP_LW && exMemInst.r.rd != '0;
  assign wbFwd = wbWrite && wbReg != '0;

  assign a = (exFwd && exMemInst.r.rd == idExInst.r.rs) ? exMemResult :
             (wbFwd && wbReg == idExInst.r.rs) ? wbData : idExRsData;
  assign b = (exFwd && exMemInst.r.rd == srcB) ? exMemResult :
             (wbFwd && wbReg == srcB) ? wbData : idExRtData;

  assign sum    = a + b;
  assign diff   = a - b;
  assign addOvf = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
  assign subOvf = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);
  assign satVal = a[W-1] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};
  assign rotPair = {a, a} >> idExInst.r.rt;
  assign memOff = {{(W - `CPU_MEM_OFF_W - 1){offset[`CPU_MEM_OFF_W-1]}}, offset, 1'b0};

  always_comb begin
    ovf = 1'b0;
    case (op)
      `CPU_OP_ADD: begin
        ovf    = addOvf;
        result = addOvf ? satVal : sum;
      end
      `CPU_OP_SUB: begin
        ovf    = subOvf;
        result = subOvf ? satVal : diff;
      end
      `CPU_OP_XOR: result = a ^ b;
      `CPU_OP_SLL: result = a << idExInst.r.rt;
      `CPU_OP_SRA: result = $signed(a) >>> idExInst.r.rt;
      `CPU_OP_ROR: result = rotPair[W-1:0];
      `CPU_OP_LW, `CPU_OP_SW:
        result = {a[W-1:1], 1'b0} + memOff;  // word aligned base plus offset
      `CPU_OP_LLB: result = {b[W-1:8], idExInst.imm.imm8};
      `CPU_OP_LHB: result = {idExInst.imm.imm8, b[7:0]};
      `CPU_OP_PCS: result = idExPcInc;  // return address
      default:     result = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      zFlag      <= 1'b0;
      vFlag      <= 1'b0;
      nFlag      <= 1'b0;
      exMemValid <= 1'b0;
    end else begin
      exMemValid <= idExValid;
      if (idExValid && setsFlags(op)) begin
        zFlag <= result == '0;
        // only the arithmetic ops touch V and N
        if (op == `CPU_OP_ADD || op == `CPU_OP_SUB) begin
          vFlag <= ovf;
          nFlag <= result[W-1];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    exMemInst      <= idExInst;
    exMemResult    <= result;
    exMemStoreData <= b;
  end

endmodule

`default_nettype wire

//--- hdl/memWriteback.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module memWriteback (
  input  logic                       clk,
  input  logic                       arstN,
  input  cpuPkg::instWord_t          exMemInst,
  input  logic                       exMemValid,
  input  logic [`CPU_WORD_W-1:0]     exMemResult,
  input  logic [`CPU_WORD_W-1:0]     exMemStoreData,
  input  logic [`CPU_WORD_W-1:0]     memRdData,
  output logic [`CPU_WORD_W-1:0]     memAddr,
  output logic [`CPU_WORD_W-1:0]     memWrData,
  output logic                       memEn,
  output logic                       memWr,
  output logic                       wbWrite,
  output logic [`CPU_REG_ADDR_W-1:0] wbReg,
  output logic [`CPU_WORD_W-1:0]     wbData,
  output logic                       hlt
);
  import cpuPkg::*;

  logic [3:0]             op;
  logic [3:0]             wbOp;
  logic                   wbValid;
  instWord_t              wbInst;
  logic [`CPU_WORD_W-1:0] wbResult;
  logic [`CPU_WORD_W-1:0] wbLoad;
  logic                   storeFwd;

  assign op      = exMemInst.r.opcode;
  assign memAddr = exMemResult;
  assign memEn   = exMemValid && (op == `CPU_OP_LW || op == `CPU_OP_SW);
  assign memWr   = exMemValid && op == `CPU_OP_SW;

  // LW directly ahead of SW on the same register, the loaded word is only here now
  assign storeFwd  = wbWrite && wbOp == `CPU_OP_LW && wbReg != '0 &&
                     wbReg == exMemInst.r.rd;
  assign memWrData = storeFwd ? wbData : exMemStoreData;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbValid <= 1'b0;
      hlt     <= 1'b0;
    end else begin
      wbValid <= exMemValid;
      if (exMemValid && op == `CPU_OP_HLT)
        hlt <= 1'b1;  // held until reset
    end
  end

  always_ff @(posedge clk) begin
    wbInst   <= exMemInst;
    wbResult <= exMemResult;
    wbLoad   <= memRdData;
  end

  assign wbOp    = wbInst.r.opcode;
  assign wbReg   = wbInst.r.rd;
  assign wbWrite = wbValid && writesReg(wbOp);
  assign wbData  = (wbOp == `CPU_OP_LW) ? wbLoad : wbResult;

endmodule

`default_nettype wire

//--- hdl/cpu.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module cpu (
  input  logic                   clk,
  input  logic                   arstN,
  output logic [`CPU_WORD_W-1:0] pc,
  input  logic [`CPU_WORD_W-1:0] instData,
  output logic [`CPU_WORD_W-1:0] memAddr,
  output logic [`CPU_WORD_W-1:0] memWrData,
  output logic                   memEn,
  output logic                   memWr,
  input  logic [`CPU_WORD_W-1:0] memRdData,
  output logic                   hlt
);
  import cpuPkg::*;

  // fetch to decode
  instWord_t              ifIdInst;
  logic [`CPU_WORD_W-1:0] ifIdPcInc;
  logic                   ifIdValid;
  logic                   stall;
  logic                   brTaken;
  logic [`CPU_WORD_W-1:0] brTarget;

  // decode to execute
  instWord_t              idExInst;
  logic [`CPU_WORD_W-1:0] idExRsData;
  logic [`CPU_WORD_W-1:0] idExRtData;
  logic [`CPU_WORD_W-1:0] idExPcInc;
  logic                   idExValid;
  logic                   zFlag;
  logic                   vFlag;
  logic                   nFlag;

  // execute to memory and the writeback return path
  instWord_t                  exMemInst;
  logic                       exMemValid;
  logic [`CPU_WORD_W-1:0]     exMemResult;
  logic [`CPU_WORD_W-1:0]     exMemStoreData;
  logic                       wbWrite;
  logic [`CPU_REG_ADDR_W-1:0] wbReg;
  logic [`CPU_WORD_W-1:0]     wbData;

  // every stage port shares its name with the net above or a top port
  fetchStage fetch (.*);

  decodeStage decode (.*);

  executeStage execute (.*);

  memWriteback memWb (.*);

endmodule

`default_nettype wire

//--- testbench/cpuChecker.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module cpuChecker (
  input logic                   clk,
  input logic                   arstN,
  input logic                   memWr,
  input logic [`CPU_WORD_W-1:0] memAddr,
  input logic [`CPU_WORD_W-1:0] memWrData,
  input logic                   hlt,
  input logic [`CPU_WORD_W-1:0] pc
);

  localparam int HoldCycles = 8;  // cycles watched once hlt is up

  // filled by the testbench before reset is released
  logic [`CPU_WORD_W-1:0] expAddr [$];
  logic [`CPU_WORD_W-1:0] expData [$];
  string                  expName [$];
  logic [`CPU_WORD_W-1:0] expHaltPc;

  int   mismatchCount = 0;
  int   otherCount = 0;
  logic done = 1'b0;
  logic hltSeen = 1'b0;
  int   holdCount = 0;

  task automatic reportMismatch(input string test, input string what,
                                input logic [`CPU_WORD_W-1:0] expVal,
                                input logic [`CPU_WORD_W-1:0] actVal);
    $display("Mismatch %s %s: expected %h actual %h", test, what, expVal, actVal);
    mismatchCount++;
  endtask

  task automatic checkStore();
    string                  name;
    logic [`CPU_WORD_W-1:0] addr;
    logic [`CPU_WORD_W-1:0] data;
    if (expAddr.size() == 0) begin
      $display("extra store to address %h with data %h beyond the expected stores",
               memAddr, memWrData);
      otherCount++;
    end else begin
      name = expName.pop_front();
      addr = expAddr.pop_front();
      data = expData.pop_front();
      if (memAddr !== addr)
        reportMismatch(name, "store address", addr, memAddr);
      if (memWrData !== data)
        reportMismatch(name, "store data", data, memWrData);
    end
  endtask

  // outputs settle after the rising edge, so the bus is read on the falling one
  always @(negedge clk) begin
    if (arstN && !done) begin
      if (memWr)
        checkStore();
      if (hlt && !hltSeen) begin
        hltSeen = 1'b1;
        if (pc !== expHaltPc)
          reportMismatch("halt", "pc", expHaltPc, pc);
        while (expAddr.size() > 0) begin
          $display("missing store in %s to address %h, the core halted first",
                   expName[0], expAddr[0]);
          otherCount++;
          void'(expName.pop_front());
          void'(expAddr.pop_front());
          void'(expData.pop_front());
        end
      end else if (hltSeen) begin
        if (pc !== expHaltPc)
          reportMismatch("halt hold", "pc", expHaltPc, pc);  // pc parks on HLT
        holdCount++;
        if (holdCount == HoldCycles)
          done = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/cpuTb.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module cpuTb;

  logic                   clk;
  logic                   arstN;
  logic [`CPU_WORD_W-1:0] pc;
  logic [`CPU_WORD_W-1:0] instData;
  logic [`CPU_WORD_W-1:0] memAddr;
  logic [`CPU_WORD_W-1:0] memWrData;
  logic                   memEn;
  logic                   memWr;
  logic [`CPU_WORD_W-1:0] memRdData;
  logic                   hlt;

  logic [`CPU_WORD_W-1:0] imem [256];
  logic [`CPU_WORD_W-1:0] dmem [256];
  string                  segName [256];  // test name of each program word
  string                  curSeg;
  int                     progLen;
  integer                 seed;
  int                     cycleCount;
  int                     cycleLimit;
  int                     timeoutCount;

  cpu DUT (
    .clk       (clk),
    .arstN     (arstN),
    .pc        (pc),
    .instData  (instData),
    .memAddr   (memAddr),
    .memWrData (memWrData),
    .memEn     (memEn),
    .memWr     (memWr),
    .memRdData (memRdData),
    .hlt       (hlt)
  );

  cpuChecker scoreboard (
    .clk       (clk),
    .arstN     (arstN),
    .memWr     (memWr),
    .memAddr   (memAddr),
    .memWrData (memWrData),
    .hlt       (hlt),
    .pc        (pc)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // both memories are word arrays indexed by the byte address
  assign instData  = imem[pc[8:1]];
  assign memRdData = memEn ? dmem[memAddr[8:1]] : 'x;  // no data unless the bus is enabled

  always @(posedge clk) begin
    if (memEn && memWr)
      dmem[memAddr[8:1]] <= memWrData;
  end

  function automatic logic [15:0] fillWord(input int idx);
    logic [7:0] w;
    w = idx[7:0];
    fillWord = {w ^ 8'h3c, ~w};
  endfunction

  function automatic logic [15:0] regWord(input logic [3:0] op, input logic [3:0] rd,
                                          input logic [3:0] rs, input logic [3:0] rt);
    regWord = {op, rd, rs, rt};
  endfunction

  function automatic logic [15:0] byteWord(input logic [3:0] op, input logic [3:0] rd,
                                           input logic [7:0] imm);
    byteWord = {op, rd, imm};
  endfunction

  task automatic emit(input logic [15:0] word);
    imem[progLen] = word;
    segName[progLen] = curSeg;
    progLen++;
  endtask

  // kind 0 gives zero, kind 1 a negative result, kind 2 a saturating overflow
  task automatic flagSetup(input int kind);
    if (kind == 0)
      emit(regWord(`CPU_OP_SUB, 4'd12, 4'd1, 4'd1));
    else if (kind == 1)
      emit(regWord(`CPU_OP_SUB, 4'd12, 4'd2, 4'd1));
    else
      emit(regWord(`CPU_OP_ADD, 4'd12, 4'd3, 4'd3));
  endtask

  // a taken B skips exactly the store behind it
  task automatic branchCase(input logic [2:0] cond, input int kind);
    flagSetup(kind);
    emit({`CPU_OP_B, cond, 9'd1});
    emit(regWord(`CPU_OP_SW, 4'd12, 4'd15, 4'd0));
  endtask

  task automatic regJumpCase(input logic [2:0] cond, input int kind);
    logic [15:0] tgt;
    tgt = (progLen + 5) * 2;
    emit(byteWord(`CPU_OP_LLB, 4'd13, tgt[7:0]));
    emit(byteWord(`CPU_OP_LHB, 4'd13, tgt[15:8]));
    flagSetup(kind);
    emit({`CPU_OP_BR, cond, 1'b0, 4'd13, 4'd0});
    emit(regWord(`CPU_OP_SW, 4'd12, 4'd15, 4'd1));
  endtask

  // BR through a register that LW filled just before
  task automatic loadJumpCase();
    logic [15:0] tgt;
    tgt = (progLen + 6) * 2;
    emit(byteWord(`CPU_OP_LLB, 4'd13, tgt[7:0]));
    emit(byteWord(`CPU_OP_LHB, 4'd13, tgt[15:8]));
    emit(regWord(`CPU_OP_SW, 4'd13, 4'd15, 4'd7));
    emit(regWord(`CPU_OP_LW, 4'd14, 4'd15, 4'd7));
    emit({`CPU_OP_BR, `CPU_CC_UN, 1'b0, 4'd14, 4'd0});
    emit(regWord(`CPU_OP_SW, 4'd12, 4'd15, 4'd2));
  endtask

  task automatic buildProgram();
    integer     r;
    int         pick;
    logic [3:0] op;
    logic [3:0] rd;
    progLen = 0;
    seed = 32'he319;
    for (int i = 0; i < 256; i++) begin
      imem[i] = {`CPU_OP_HLT, 12'h000};
      dmem[i] = fillWord(i);
    end
    curSeg = "init";
    emit(byteWord(`CPU_OP_LLB, 4'd1, 8'h05));
    emit(byteWord(`CPU_OP_LLB, 4'd2, 8'h03));
    emit(byteWord(`CPU_OP_LHB, 4'd3, 8'h70));
    emit(byteWord(`CPU_OP_LLB, 4'd15, 8'h80));  // r15 is the store base
    emit(byteWord(`CPU_OP_LLB, 4'd8, 8'h01));
    emit(byteWord(`CPU_OP_LHB, 4'd8, 8'h80));
    emit(byteWord(`CPU_OP_LLB, 4'd9, 8'h34));
    emit(byteWord(`CPU_OP_LHB, 4'd9, 8'h12));
    curSeg = "alu chain";
    emit(regWord(`CPU_OP_ADD, 4'd4, 4'd3, 4'd3));
    emit(regWord(`CPU_OP_SUB, 4'd5, 4'd4, 4'd9));
    emit(regWord(`CPU_OP_XOR, 4'd6, 4'd5, 4'd4));
    emit(regWord(`CPU_OP_SLL, 4'd7, 4'd6, 4'd3));
    emit(regWord(`CPU_OP_SRA, 4'd10, 4'd8, 4'd4));
    emit(regWord(`CPU_OP_ROR, 4'd11, 4'd9, 4'd5));
    emit(regWord(`CPU_OP_ADD, 4'd13, 4'd10, 4'd11));
    emit(regWord(`CPU_OP_SUB, 4'd12, 4'd8, 4'd3));
    emit(regWord(`CPU_OP_SUB, 4'd14, 4'd3, 4'd8));
    emit(regWord(`CPU_OP_SW, 4'd4, 4'd15, 4'd0));
    emit(regWord(`CPU_OP_SW, 4'd5, 4'd15, 4'd1));
    emit(regWord(`CPU_OP_SW, 4'd6, 4'd15, 4'd2));
    emit(regWord(`CPU_OP_SW, 4'd7, 4'd15, 4'd3));
    emit(regWord(`CPU_OP_SW, 4'd10, 4'd15, 4'd4));
    emit(regWord(`CPU_OP_SW, 4'd11, 4'd15, 4'd5));
    emit(regWord(`CPU_OP_SW, 4'd13, 4'd15, 4'd6));
    emit(regWord(`CPU_OP_SW, 4'd12, 4'd15, 4'd7));
    emit(regWord(`CPU_OP_SW, 4'd14, 4'd15, 4'hf));
    curSeg = "load use";
    emit(regWord(`CPU_OP_LW, 4'd4, 4'd15, 4'he));
    emit(regWord(`CPU_OP_ADD, 4'd5, 4'd4, 4'd1));
    emit(regWord(`CPU_OP_SW, 4'd5, 4'd15, 4'hd));
    emit(regWord(`CPU_OP_LW, 4'd6, 4'd15, 4'hc));
    emit(regWord(`CPU_OP_SW, 4'd6, 4'd15, 4'hb));
    emit(regWord(`CPU_OP_LW, 4'd7, 4'd15, 4'd1));
    emit(regWord(`CPU_OP_SUB, 4'd10, 4'd9, 4'd7));
    emit(regWord(`CPU_OP_SW, 4'd10, 4'd15, 4'ha));
    curSeg = "byte load and pcs";
    emit(byteWord(`CPU_OP_LLB, 4'd4, 8'hab));
    emit(byteWord(`CPU_OP_LHB, 4'd4, 8'hcd));
    emit(regWord(`CPU_OP_SW, 4'd4, 4'd15, 4'h9));
    emit(regWord(`CPU_OP_PCS, 4'd5, 4'd0, 4'd0));
    emit(regWord(`CPU_OP_SW, 4'd5, 4'd15, 4'h8));
    emit(byteWord(`CPU_OP_LHB, 4'd6, 8'h5a));
    emit(regWord(`CPU_OP_SW, 4'd6, 4'd15, 4'd7));
    curSeg = "branch B";
    for (int c = 0; c < 8; c++)
      for (int k = 0; k < 3; k++)
        branchCase(c[2:0], k);
    curSeg = "branch BR";
    regJumpCase(`CPU_CC_EQ, 0);
    regJumpCase(`CPU_CC_EQ, 1);
    regJumpCase(`CPU_CC_LT, 1);
    regJumpCase(`CPU_CC_OV, 2);
    regJumpCase(`CPU_CC_GE, 1);
    loadJumpCase();
    curSeg = "random";
    for (int k = 1; k <= 6; k++) begin
      r = $random(seed);
      emit(byteWord(`CPU_OP_LLB, k[3:0], r[7:0]));
      emit(byteWord(`CPU_OP_LHB, k[3:0], r[15:8]));
    end
    for (int k = 0; k < 40; k++) begin
      r = $random(seed);
      pick = r[6:4] % 6;
      op = (pick < 3) ? pick : pick + 1;  // skips the unused opcode 3
      rd = 4'd1 + r[3:0] % 14;
      emit(regWord(op, rd, r[11:8], r[15:12]));
      emit(regWord(`CPU_OP_SW, rd, 4'd15, {1'b0, r[18:16]}));
    end
    curSeg = "halt";
    emit({`CPU_OP_HLT, 12'h000});
  endtask

  function automatic logic condHolds(input logic [2:0] cond, input logic z,
                                     input logic v, input logic n);
    case (cond)
      `CPU_CC_NE: condHolds = !z;
      `CPU_CC_EQ: condHolds = z;
      `CPU_CC_GT: condHolds = !z && !n;
      `CPU_CC_LT: condHolds = n;
      `CPU_CC_GE: condHolds = z || !n;
      `CPU_CC_LE: condHolds = z || n;
      `CPU_CC_OV: condHolds = v;
      default:    condHolds = 1'b1;
    endcase
  endfunction

  // top bit is the overflow, the low word the clamped result
  function automatic logic [16:0] satArith(input logic [15:0] x, input logic [15:0] y,
                                           input logic sub);
    int sx;
    int sy;
    int r;
    sx = $signed(x);
    sy = $signed(y);
    r = sub ? sx - sy : sx + sy;
    if (r > 32767)
      satArith = {1'b1, 16'h7fff};
    else if (r < -32768)
      satArith = {1'b1, 16'h8000};
    else
      satArith = {1'b0, r[15:0]};
  endfunction

  // runs the program one instruction at a time and queues every store
  function automatic void runModel();
    logic [15:0] regs [16];
    logic [15:0] mem [256];
    logic [15:0] pcM;
    logic [15:0] nextPc;
    logic [15:0] inst;
    logic [15:0] a;
    logic [15:0] res;
    logic [15:0] addr;
    logic [16:0] arith;
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [3:0]  rt;
    logic        zf;
    logic        vf;
    logic        nf;
    logic        halted;
    int          steps;
    for (int i = 0; i < 16; i++)
      regs[i] = '0;
    for (int i = 0; i < 256; i++)
      mem[i] = fillWord(i);
    pcM = '0;
    zf = 1'b0;
    vf = 1'b0;
    nf = 1'b0;
    halted = 1'b0;
    steps = 0;
    while (!halted && steps < 4096) begin
      inst = imem[pcM[8:1]];
      op = inst[15:12];
      rd = inst[11:8];
      rt = inst[3:0];
      a = regs[inst[7:4]];
      addr = {a[15:1], 1'b0} + {{11{rt[3]}}, rt, 1'b0};
      nextPc = pcM + 16'd2;
      steps++;
      case (op)
        `CPU_OP_ADD, `CPU_OP_SUB: begin
          arith = satArith(a, regs[rt], op == `CPU_OP_SUB);
          regs[rd] = arith[15:0];
          zf = arith[15:0] == '0;
          vf = arith[16];
          nf = arith[15];
        end
        `CPU_OP_XOR, `CPU_OP_SLL, `CPU_OP_SRA, `CPU_OP_ROR: begin
          if (op == `CPU_OP_XOR)
            res = a ^ regs[rt];
          else if (op == `CPU_OP_SLL)
            res = a << rt;
          else if (op == `CPU_OP_SRA)
            res = $signed(a) >>> rt;
          else
            res = (a >> rt) | (a << (16 - rt));
          regs[rd] = res;
          zf = res == '0;  // V and N are left alone
        end
        `CPU_OP_LW: regs[rd] = mem[addr[8:1]];
        `CPU_OP_SW: begin
          mem[addr[8:1]] = regs[rd];
          scoreboard.expAddr.push_back(addr);
          scoreboard.expData.push_back(regs[rd]);
          scoreboard.expName.push_back(segName[pcM[8:1]]);
        end
        `CPU_OP_LLB: regs[rd] = {regs[rd][15:8], inst[7:0]};
        `CPU_OP_LHB: regs[rd] = {inst[7:0], regs[rd][7:0]};
        `CPU_OP_B: begin
          if (condHolds(inst[11:9], zf, vf, nf))
            nextPc = pcM + 16'd2 + {{6{inst[8]}}, inst[8:0], 1'b0};
        end
        `CPU_OP_BR: begin
          if (condHolds(inst[11:9], zf, vf, nf))
            nextPc = a;
        end
        `CPU_OP_PCS: regs[rd] = pcM + 16'd2;
        `CPU_OP_HLT: begin
          halted = 1'b1;
          scoreboard.expHaltPc = pcM;
        end
        default: ;  // opcodes 3 and 7 do nothing
      endcase
      regs[0] = '0;
      if (!halted)
        pcM = nextPc;
    end
  endfunction

  initial begin
    arstN = 1'b0;
    cycleCount = 0;
    timeoutCount = 0;
    buildProgram();
    runModel();
    cycleLimit = 4 * progLen + 20;
    repeat (4) @(posedge clk);
    arstN <= 1'b1;
    while (!scoreboard.done && cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    if (!scoreboard.done) begin
      $display("timeout: the core did not halt within %0d cycles after reset", cycleLimit);
      timeoutCount = 1;
    end
    $display("errors: %0d mismatches, %0d other failures",
             scoreboard.mismatchCount, scoreboard.otherCount + timeoutCount);
    if (scoreboard.mismatchCount + scoreboard.otherCount + timeoutCount == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- cpu.f
+incdir+hdl
hdl/cpuPkg.sv
hdl/registerFile.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memWriteback.sv
hdl/cpu.sv
testbench/cpuChecker.sv
testbench/cpuTb.sv
